// File: menu_pointer_top.f
hdl/menu_pkg.sv
hdl/key_pulse.sv
hdl/menu_fsm.sv
hdl/pointer_position.sv
hdl/vga_timing.sv
hdl/pointer_draw.sv
hdl/menu_pointer_top.sv
bench/clk_gen.sv
bench/menu_pointer_tb.sv

// File: Makefile
TB = menu_pointer_tb

all: run

build:
	verilator --binary --timing --assert -j 0 -f menu_pointer_top.f --top-module $(TB) -o $(TB)

run: build
	./obj_dir/$(TB) | tee sim.log
	grep -q "all tests passed" sim.log

lint:
	verilator --lint-only -Wall --timing -f menu_pointer_top.f --top-module menu_pointer_top

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

// File: bench/menu_pointer_tb.sv
`timescale 1ns/1ps

module menu_pointer_tb;
    import menu_pkg::*;

    localparam int H_ACTIVE = 800, H_FRONT = 40, H_SYNC = 128, H_BACK = 88;
    localparam int V_ACTIVE = 600, V_FRONT = 1, V_SYNC = 4, V_BACK = 23;
    localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int POINTER_SIZE = 16;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int RESET_CYCLES = 10;
    localparam int DIRECTED_PRESSES = 37;
    localparam int RANDOM_PRESSES = 200;
    // Longest press is a 3 cycle hold plus a 13 cycle gap
    localparam int CYCLE_LIMIT = RESET_CYCLES + 20
        + (DIRECTED_PRESSES + RANDOM_PRESSES + 1) * 16 + 2 * FRAME_CYCLES + 1000;
    localparam int KEY_UP = 0, KEY_DOWN = 1, KEY_ENTER = 2, KEY_BACK = 3;

    // Visits every screen and wraps both counters
    int directed_seq [DIRECTED_PRESSES] = '{
        KEY_DOWN, KEY_DOWN, KEY_DOWN, KEY_DOWN, KEY_UP, KEY_UP, KEY_UP, KEY_UP,
        KEY_ENTER, KEY_UP, KEY_DOWN, KEY_BACK,
        KEY_DOWN, KEY_ENTER, KEY_UP, KEY_BACK,
        KEY_DOWN, KEY_DOWN, KEY_ENTER, KEY_DOWN, KEY_ENTER, KEY_BACK,
        KEY_DOWN, KEY_DOWN, KEY_DOWN, KEY_ENTER, KEY_DOWN, KEY_DOWN, KEY_UP, KEY_ENTER,
        KEY_DOWN, KEY_DOWN, KEY_DOWN, KEY_ENTER, KEY_ENTER, KEY_BACK, KEY_BACK
    };

    logic        clk, rst, btn_up, btn_down, btn_enter, btn_back;
    menu_state_t menu_state;
    item_idx_t   menu_counter;
    logic        game_active, exit_request, hsync, vsync;
    coord_t      x_pointer, y_pointer, pix_x, pix_y;
    rgb_t        rgb;

    // Reference model and bookkeeping
    logic [3:0]  btn_last = '0, rise_s1 = '0, rise_s2 = '0, press_ev = '0;
    menu_state_t exp_state;
    item_idx_t   exp_counter;
    logic        exp_exit;
    logic [1:0]  rst_hist;
    coord_t      exp_x, exp_y, ptr_x_q, ptr_y_q;
    coord_t      h_model, v_model, exp_pix_x, exp_pix_y;
    logic [7:0]  screens_seen = '0;
    int          exit_pulses = 0, pointer_pixels = 0, cycle_count = 0;
    int          value_errors = 0, other_errors = 0;
    integer      seed;

    clk_gen #(.PERIOD_NS(8.0)) clk_gen_i (.clk);

    menu_pointer_top #(
        .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK),
        .POINTER_SIZE(POINTER_SIZE)
    ) menu_pointer_top_i (
        .clk, .rst, .btn_up, .btn_down, .btn_enter, .btn_back, .menu_state, .menu_counter,
        .game_active, .exit_request, .x_pointer, .y_pointer, .rgb, .hsync, .vsync,
        .pix_x, .pix_y
    );

    function automatic coord_t expected_x(input menu_state_t s);
        case (s)
            MAIN:           return MAIN_X;
            EXIT:           return EXIT_X;
            CONTROL, ABOUT: return BACK_X;
            default:        return HIDDEN_X;
        endcase
    endfunction

    function automatic coord_t expected_y(input menu_state_t s, input item_idx_t c);
        case (s)
            MAIN:           return MAIN_Y0 + ITEM_PITCH * c;
            EXIT:           return EXIT_Y0 + ITEM_PITCH * c;
            CONTROL, ABOUT: return BACK_Y;
            default:        return HIDDEN_Y;
        endcase
    endfunction

    function automatic rgb_t expected_rgb(input coord_t px, input coord_t py,
                                          input coord_t ptx, input coord_t pty);
        if (px >= H_ACTIVE || py >= V_ACTIVE)
            return 12'h000;
        if (px >= ptx && px < ptx + POINTER_SIZE && py >= pty && py < pty + POINTER_SIZE)
            return POINTER_RGB;
        return BACKGROUND_RGB;
    endfunction

    //////////////////////////////////////////////////
    // Reference model with presses applied 4 edges after the button rises
    //////////////////////////////////////////////////
    always @(posedge clk) begin : reference_model
        menu_state_t st;
        int          cnt;
        int          items;
        logic        ex;
        btn_last <= {btn_back, btn_enter, btn_down, btn_up};
        rise_s1  <= {btn_back, btn_enter, btn_down, btn_up} & ~btn_last;
        rise_s2  <= rise_s1;
        press_ev <= rst ? 4'b0000 : rise_s2;
        rst_hist <= {rst_hist[0], rst};
        ptr_x_q  <= x_pointer;
        ptr_y_q  <= y_pointer;
        st    = exp_state;
        cnt   = int'(exp_counter);
        ex    = 1'b0;
        items = (st == MAIN) ? MAIN_ITEMS : (st == EXIT) ? EXIT_ITEMS : 0;
        if (press_ev[KEY_BACK]) begin
            if (st != MAIN) begin
                st  = MAIN;
                cnt = 0;
            end
        end else if (press_ev[KEY_ENTER]) begin
            if (st == MAIN) begin
                st  = menu_state_t'(cnt + 1);
                cnt = 0;
            end else if (st == EXIT && cnt == 0) begin
                ex = 1'b1;
            end else if (st == EXIT) begin
                st  = MAIN;
                cnt = 0;
            end
        end else if (press_ev[KEY_UP] && items > 0) begin
            cnt = (cnt + items - 1) % items;
        end else if (press_ev[KEY_DOWN] && items > 0) begin
            cnt = (cnt + 1) % items;
        end
        if (rst) begin
            exp_state   <= MAIN;
            exp_counter <= '0;
            exp_exit    <= 1'b0;
            exp_x       <= '0;
            exp_y       <= '0;
        end else begin
            exp_state   <= st;
            exp_counter <= item_idx_t'(cnt);
            exp_exit    <= ex;
            exp_x       <= expected_x(exp_state);
            exp_y       <= expected_y(exp_state, exp_counter);
        end
    end

    // Scan position, with the pixel outputs one cycle behind it
    always @(posedge clk) begin : scan_model
        if (rst) begin
            h_model   <= '0;
            v_model   <= '0;
            exp_pix_x <= '0;
            exp_pix_y <= '0;
        end else begin
            exp_pix_x <= h_model;
            exp_pix_y <= v_model;
            if (h_model == coord_t'(H_TOTAL - 1)) begin
                h_model <= '0;
                v_model <= (v_model == coord_t'(V_TOTAL - 1)) ? '0 : v_model + 11'd1;
            end else begin
                h_model <= h_model + 11'd1;
            end
        end
    end

    task automatic report_value_error(input string name, input int expected, input int actual);
        value_errors++;
        $display("Error at %0t ns: %s expected %0d, actual %0d", $time, name, expected, actual);
    endtask

    task automatic report_failure(input string what);
        other_errors++;
        $display("Failure at %0t ns: %s", $time, what);
    endtask

    //////////////////////////////////////////////////
    // Assertions
    //////////////////////////////////////////////////
    assert property (@(posedge clk) disable iff (rst) menu_state == exp_state)
        else report_value_error("menu_state", $sampled(exp_state), $sampled(menu_state));
    assert property (@(posedge clk) disable iff (rst) menu_counter == exp_counter)
        else report_value_error("menu_counter", $sampled(exp_counter), $sampled(menu_counter));
    assert property (@(posedge clk) disable iff (rst) game_active == (exp_state == START_GAME))
        else report_value_error("game_active", $sampled(exp_state == START_GAME),
                                $sampled(game_active));
    assert property (@(posedge clk) disable iff (rst) exit_request == exp_exit)
        else report_value_error("exit_request", $sampled(exp_exit), $sampled(exit_request));
    assert property (@(posedge clk) disable iff (rst) x_pointer == exp_x)
        else report_value_error("x_pointer", $sampled(exp_x), $sampled(x_pointer));
    assert property (@(posedge clk) disable iff (rst) y_pointer == exp_y)
        else report_value_error("y_pointer", $sampled(exp_y), $sampled(y_pointer));
    assert property (@(posedge clk) disable iff (rst) pix_x == exp_pix_x)
        else report_value_error("pix_x", $sampled(exp_pix_x), $sampled(pix_x));
    assert property (@(posedge clk) disable iff (rst) pix_y == exp_pix_y)
        else report_value_error("pix_y", $sampled(exp_pix_y), $sampled(pix_y));

    // Pixel path once the reset has left the pixel register
    assert property (@(posedge clk) disable iff (rst || rst_hist != 2'b00)
        rgb == expected_rgb(pix_x, pix_y, ptr_x_q, ptr_y_q))
        else report_value_error("rgb", $sampled(expected_rgb(pix_x, pix_y, ptr_x_q, ptr_y_q)),
                                $sampled(rgb));
    assert property (@(posedge clk) disable iff (rst || rst_hist != 2'b00)
        hsync == !(pix_x >= H_ACTIVE + H_FRONT && pix_x < H_ACTIVE + H_FRONT + H_SYNC))
        else report_value_error("hsync", !$sampled(hsync), $sampled(hsync));
    assert property (@(posedge clk) disable iff (rst || rst_hist != 2'b00)
        vsync == !(pix_y >= V_ACTIVE + V_FRONT && pix_y < V_ACTIVE + V_FRONT + V_SYNC))
        else report_value_error("vsync", !$sampled(vsync), $sampled(vsync));

    // What the stimulus has reached so far
    always @(posedge clk) begin
        if (!rst) begin
            screens_seen[menu_state] <= 1'b1;
            if (exit_request)
                exit_pulses <= exit_pulses + 1;
            if (rst_hist == 2'b00 && rgb == POINTER_RGB)
                pointer_pixels <= pointer_pixels + 1;
        end
    end

    // Hold 3 cycles, then a random gap of 6 to 13 cycles
    task automatic press_button(input int key);
        int gap;
        case (key)
            KEY_UP:    btn_up <= 1'b1;
            KEY_DOWN:  btn_down <= 1'b1;
            KEY_ENTER: btn_enter <= 1'b1;
            default:   btn_back <= 1'b1;
        endcase
        repeat (3) @(posedge clk);
        {btn_back, btn_enter, btn_down, btn_up} <= 4'b0000;
        gap = 6 + int'($unsigned($random(seed)) % 8);
        repeat (gap) @(posedge clk);
    endtask

    task automatic wait_frame_start();
        @(posedge clk);
        while (!(pix_x == '0 && pix_y == '0))
            @(posedge clk);
    endtask

    task automatic check_reset_values();
        assert (menu_state == MAIN) else report_value_error("menu_state", MAIN, menu_state);
        assert (menu_counter == '0) else report_value_error("menu_counter", 0, menu_counter);
        assert (!game_active) else report_value_error("game_active", 0, game_active);
        assert (!exit_request) else report_value_error("exit_request", 0, exit_request);
        assert (hsync && vsync) else report_value_error("hsync&vsync", 1, hsync && vsync);
        assert (rgb == '0) else report_value_error("rgb", 0, rgb);
    endtask

    initial begin
        seed = 32'he1e6_ab9d;
        rst = 1'b1;
        // Up held through reset must not count as a press
        btn_up = 1'b1;
        btn_down = 1'b0;
        btn_enter = 1'b0;
        btn_back = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_reset_values();
        repeat (4) @(posedge clk);
        btn_up <= 1'b0;
        repeat (8) @(posedge clk);
        foreach (directed_seq[i])
            press_button(directed_seq[i]);
        repeat (RANDOM_PRESSES)
            press_button(int'($unsigned($random(seed)) % 4));
        // Settle on a visible pointer, then draw one whole frame
        press_button(KEY_BACK);
        wait_frame_start();
        wait_frame_start();
        if (screens_seen[4:0] != 5'b11111)
            report_failure("not every menu screen was reached");
        if (exit_pulses == 0)
            report_failure("exit_request never pulsed");
        if (pointer_pixels < POINTER_SIZE * POINTER_SIZE)
            report_failure("pointer square was not drawn in full");
        $display("Summary: %0d value errors, %0d other errors", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            report_failure("run did not finish within the cycle limit");
            $display("Summary: %0d value errors, %0d other errors", value_errors, other_errors);
            $display("tests failed");
            $finish;
        end
    end

endmodule

// File: bench/clk_gen.sv
`timescale 1ns/1ps

module clk_gen #(
    parameter real PERIOD_NS = 8.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

endmodule

// File: hdl/menu_pointer_top.sv
`timescale 1ns/1ps

module menu_pointer_top #(
    parameter int H_ACTIVE     = 800,
    parameter int H_FRONT      = 40,
    parameter int H_SYNC       = 128,
    parameter int H_BACK       = 88,
    parameter int V_ACTIVE     = 600,
    parameter int V_FRONT      = 1,
    parameter int V_SYNC       = 4,
    parameter int V_BACK       = 23,
    parameter int POINTER_SIZE = 16
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  btn_up,
    input  logic                  btn_down,
    input  logic                  btn_enter,
    input  logic                  btn_back,
    output menu_pkg::menu_state_t menu_state,
    output menu_pkg::item_idx_t   menu_counter,
    output logic                  game_active,
    output logic                  exit_request,
    output menu_pkg::coord_t      x_pointer,
    output menu_pkg::coord_t      y_pointer,
    output menu_pkg::rgb_t        rgb,
    output logic                  hsync,
    output logic                  vsync,
    output menu_pkg::coord_t      pix_x,
    output menu_pkg::coord_t      pix_y
);
    import menu_pkg::*;

    logic   up_press, down_press, enter_press, back_press;
    coord_t hcount, vcount;
    logic   hsync_raw, vsync_raw, blank;

    // Menu control
    key_pulse key_pulse_i (.clk, .rst, .btn_up, .btn_down, .btn_enter, .btn_back,
                           .up_press, .down_press, .enter_press, .back_press);

    menu_fsm menu_fsm_i (.clk, .rst, .up_press, .down_press, .enter_press, .back_press,
                         .menu_state, .menu_counter, .game_active, .exit_request);

    pointer_position pointer_position_i (.clk, .rst, .menu_state, .menu_counter,
                                         .x_pointer, .y_pointer);

    // Video path
    vga_timing #(
        .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
    ) vga_timing_i (.clk, .rst, .hcount, .vcount, .hsync(hsync_raw), .vsync(vsync_raw), .blank);

    pointer_draw #(.POINTER_SIZE(POINTER_SIZE)) pointer_draw_i (
        .clk, .rst, .hcount, .vcount, .hsync(hsync_raw), .vsync(vsync_raw), .blank,
        .x_pointer, .y_pointer, .rgb, .hsync_out(hsync), .vsync_out(vsync), .pix_x, .pix_y
    );

endmodule

// File: hdl/pointer_draw.sv
`timescale 1ns/1ps

module pointer_draw #(
    parameter int POINTER_SIZE = 16
) (
    input  logic             clk,
    input  logic             rst,
    input  menu_pkg::coord_t hcount,
    input  menu_pkg::coord_t vcount,
    input  logic             hsync,
    input  logic             vsync,
    input  logic             blank,
    input  menu_pkg::coord_t x_pointer,
    input  menu_pkg::coord_t y_pointer,
    output menu_pkg::rgb_t   rgb,
    output logic             hsync_out,
    output logic             vsync_out,
    output menu_pkg::coord_t pix_x,
    output menu_pkg::coord_t pix_y
);
    import menu_pkg::*;

    // One extra bit so the far edge cannot wrap
    logic [11:0] x_end;
    logic [11:0] y_end;
    logic        in_square;
    rgb_t        rgb_nxt;

    assign x_end = {1'b0, x_pointer} + 12'(POINTER_SIZE);
    assign y_end = {1'b0, y_pointer} + 12'(POINTER_SIZE);

    assign in_square = (hcount >= x_pointer) && ({1'b0, hcount} < x_end)
                    && (vcount >= y_pointer) && ({1'b0, vcount} < y_end);

    // Park position lies in the blanking interval, never drawn
    assign rgb_nxt = blank     ? 12'h000 :
                     in_square ? POINTER_RGB : BACKGROUND_RGB;

    //////////////////////////////////////////////////
    // Pixel register with syncs and position kept aligned
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            rgb       <= '0;
            hsync_out <= 1'b1;
            vsync_out <= 1'b1;
            pix_x     <= '0;
            pix_y     <= '0;
        end else begin
            rgb       <= rgb_nxt;
            hsync_out <= hsync;
            vsync_out <= vsync;
            pix_x     <= hcount;
            pix_y     <= vcount;
        end
    end

endmodule

// File: hdl/vga_timing.sv
`timescale 1ns/1ps

module vga_timing #(
    parameter int H_ACTIVE = 800,
    parameter int H_FRONT  = 40,
    parameter int H_SYNC   = 128,
    parameter int H_BACK   = 88,
    parameter int V_ACTIVE = 600,
    parameter int V_FRONT  = 1,
    parameter int V_SYNC   = 4,
    parameter int V_BACK   = 23
) (
    input  logic             clk,
    input  logic             rst,
    output menu_pkg::coord_t hcount,
    output menu_pkg::coord_t vcount,
    output logic             hsync,
    output logic             vsync,
    output logic             blank
);
    import menu_pkg::*;

    localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

    // Sync windows with inclusive start and exclusive end
    localparam int H_SYNC_START = H_ACTIVE + H_FRONT;
    localparam int H_SYNC_END   = H_SYNC_START + H_SYNC;
    localparam int V_SYNC_START = V_ACTIVE + V_FRONT;
    localparam int V_SYNC_END   = V_SYNC_START + V_SYNC;

    //////////////////////////////////////////////////
    // Pixel and line counters
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            hcount <= '0;
            vcount <= '0;
        end else if (hcount == coord_t'(H_TOTAL - 1)) begin
            hcount <= '0;
            // Next line or wrap to the top of the frame
            if (vcount == coord_t'(V_TOTAL - 1))
                vcount <= '0;
            else
                vcount <= vcount + 11'd1;
        end else begin
            hcount <= hcount + 11'd1;
        end
    end

    // Decoded from the counters so they line up with hcount/vcount
    assign hsync = !(hcount >= coord_t'(H_SYNC_START) && hcount < coord_t'(H_SYNC_END));
    assign vsync = !(vcount >= coord_t'(V_SYNC_START) && vcount < coord_t'(V_SYNC_END));
    assign blank = (hcount >= coord_t'(H_ACTIVE)) || (vcount >= coord_t'(V_ACTIVE));

    assert property (@(posedge clk) disable iff (rst) hcount < coord_t'(H_TOTAL))
        else $error("vga_timing: hcount %0d beyond line length", hcount);

endmodule

// File: hdl/pointer_position.sv
`timescale 1ns/1ps

module pointer_position (
    input  logic                  clk,
    input  logic                  rst,
    input  menu_pkg::menu_state_t menu_state,
    input  menu_pkg::item_idx_t   menu_counter,
    output menu_pkg::coord_t      x_pointer,
    output menu_pkg::coord_t      y_pointer
);
    import menu_pkg::*;

    coord_t x_pointer_nxt;
    coord_t y_pointer_nxt;

    //////////////////////////////////////////////////
    // Output register
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            x_pointer <= '0;
            y_pointer <= '0;
        end else begin
            x_pointer <= x_pointer_nxt;
            y_pointer <= y_pointer_nxt;
        end
    end

    //////////////////////////////////////////////////
    // Screen and row to sprite corner
    //////////////////////////////////////////////////
    always_comb begin
        case (menu_state)
            MAIN: begin
                // All four counter values are rows on Main
                x_pointer_nxt = MAIN_X;
                y_pointer_nxt = MAIN_Y0 + coord_t'(menu_counter) * ITEM_PITCH;
            end

            EXIT: begin
                x_pointer_nxt = EXIT_X;
                y_pointer_nxt = EXIT_Y0 + coord_t'(menu_counter) * ITEM_PITCH;
            end

            // Info screens only show the back marker
            CONTROL, ABOUT: begin
                x_pointer_nxt = BACK_X;
                y_pointer_nxt = BACK_Y;
            end

            // No pointer while the game runs
            START_GAME: begin
                x_pointer_nxt = HIDDEN_X;
                y_pointer_nxt = HIDDEN_Y;
            end

            default: begin
                x_pointer_nxt = HIDDEN_X;
                y_pointer_nxt = HIDDEN_Y;
            end
        endcase
    end

endmodule

// File: hdl/menu_fsm.sv
`timescale 1ns/1ps

module menu_fsm (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  up_press,
    input  logic                  down_press,
    input  logic                  enter_press,
    input  logic                  back_press,
    output menu_pkg::menu_state_t menu_state,
    output menu_pkg::item_idx_t   menu_counter,
    output logic                  game_active,
    output logic                  exit_request
);
    import menu_pkg::*;

    menu_state_t state_nxt;
    item_idx_t   counter_nxt;
    logic        exit_nxt;

    // Selectable rows per screen (0 where up/down do nothing)
    function automatic int item_count(input menu_state_t s);
        case (s)
            MAIN:    return MAIN_ITEMS;
            EXIT:    return EXIT_ITEMS;
            default: return 0;
        endcase
    endfunction

    //////////////////////////////////////////////////
    // Next state with priority back > enter > up > down
    //////////////////////////////////////////////////
    always_comb begin
        int        count;
        item_idx_t last;
        count       = item_count(menu_state);
        last        = item_idx_t'(count - 1);
        state_nxt   = menu_state;
        counter_nxt = menu_counter;
        exit_nxt    = 1'b0;
        if (back_press) begin
            if (menu_state != MAIN) begin
                state_nxt   = MAIN;
                counter_nxt = '0;
            end
        end else if (enter_press) begin
            case (menu_state)
                MAIN: begin
                    state_nxt   = menu_state_t'({1'b0, menu_counter} + 3'd1);
                    counter_nxt = '0;
                end
                EXIT: begin
                    if (menu_counter == '0) begin
                        exit_nxt = 1'b1;
                    end else begin
                        state_nxt   = MAIN;
                        counter_nxt = '0;
                    end
                end
                default: ;
            endcase
        end else if (up_press) begin
            if (count != 0)
                counter_nxt = (menu_counter == '0) ? last : menu_counter - 2'd1;
        end else if (down_press) begin
            if (count != 0)
                counter_nxt = (menu_counter == last) ? '0 : menu_counter + 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            menu_state   <= MAIN;
            menu_counter <= '0;
            exit_request <= 1'b0;
        end else begin
            menu_state   <= state_nxt;
            menu_counter <= counter_nxt;
            exit_request <= exit_nxt;
        end
    end

    assign game_active = (menu_state == START_GAME);

    // Row index valid for the screen shown
    assert property (@(posedge clk) disable iff (rst)
        (item_count(menu_state) == 0) ? (menu_counter == '0)
                                      : (int'(menu_counter) < item_count(menu_state)))
        else $error("menu_fsm: counter %0d out of range on screen %0d", menu_counter, menu_state);

    assert property (@(posedge clk) disable iff (rst) exit_request |-> menu_state == EXIT)
        else $error("menu_fsm: exit_request outside EXIT");

endmodule

// File: hdl/key_pulse.sv
`timescale 1ns/1ps

module key_pulse (
    input  logic clk,
    input  logic rst,
    input  logic btn_up,
    input  logic btn_down,
    input  logic btn_enter,
    input  logic btn_back,
    output logic up_press,
    output logic down_press,
    output logic enter_press,
    output logic back_press
);

    // Back, enter, down and up from MSB to LSB
    logic [3:0] sync1;
    logic [3:0] sync2;
    logic [3:0] hist;
    logic [3:0] press_q;

    // Two synchronizing flops and the history flop
    always_ff @(posedge clk) begin
        sync1 <= {btn_back, btn_enter, btn_down, btn_up};
        sync2 <= sync1;
        hist  <= sync2;
    end

    // Rising edge of the synchronized level
    always_ff @(posedge clk) begin
        if (rst) begin
            press_q <= '0;
        end else begin
            press_q <= sync2 & ~hist;
        end
    end

    assign up_press    = press_q[0];
    assign down_press  = press_q[1];
    assign enter_press = press_q[2];
    assign back_press  = press_q[3];

    // A single rising edge never stretches into two pulses
    assert property (@(posedge clk) disable iff (rst) (press_q & $past(press_q)) == 4'b0000)
        else $error("key_pulse: press high on two consecutive cycles (%b)", press_q);

endmodule

// File: hdl/menu_pkg.sv
package menu_pkg;

    //////////////////////////////////////////////////
    // Types
    //////////////////////////////////////////////////

    // Pixel coordinate wide enough for the park position
    typedef logic [10:0] coord_t;

    // Highlighted row on the current screen
    typedef logic [1:0] item_idx_t;

    // 4 bits per channel with R in the top nibble
    typedef logic [11:0] rgb_t;

    typedef enum logic [2:0] {
        MAIN       = 3'd0,
        START_GAME = 3'd1,
        CONTROL    = 3'd2,
        ABOUT      = 3'd3,
        EXIT       = 3'd4
    } menu_state_t;

    //////////////////////////////////////////////////
    // Menu layout
    //////////////////////////////////////////////////

    // Main item i selects screen i+1
    localparam int MAIN_ITEMS = 4;
    // Exit item 0 confirms and item 1 cancels
    localparam int EXIT_ITEMS = 2;

    // Park position right of the visible area
    localparam coord_t HIDDEN_X   = 11'd1024;
    localparam coord_t HIDDEN_Y   = 11'd0;
    localparam coord_t MAIN_X     = 11'd451;
    localparam coord_t MAIN_Y0    = 11'd228;
    localparam coord_t EXIT_X     = 11'd435;
    localparam coord_t EXIT_Y0    = 11'd244;
    localparam coord_t BACK_X     = 11'd523;
    localparam coord_t BACK_Y     = 11'd340;
    localparam coord_t ITEM_PITCH = 11'd32;

    localparam rgb_t POINTER_RGB    = 12'hfc0;
    localparam rgb_t BACKGROUND_RGB = 12'h125;

endpackage
